//--- src/eeg_cmd_pkg.sv
// EEG accelerator command package with opcodes, field types and the command word layout
package eeg_cmd_pkg;

    // ====================
    // Opcodes
    // ====================

    // Low 4 bits of every command word, value 9 is unused
    typedef enum logic [3:0] {
        ITOA     = 4'd0,
        ITOW     = 4'd1,
        OTOA     = 4'd2,
        ATOW     = 4'd3,
        WTOA     = 4'd4,
        CONV     = 4'd5,
        POOL     = 4'd6,
        STAT     = 4'd7,
        READ     = 4'd8,
        MULT     = 4'd10,
        BIAS     = 4'd11,
        INF_CONV = 4'd12,
        INF_ARAM = 4'd13,
        INF_WRAM = 4'd14,
        INF_ORAM = 4'd15
    } opcode_e;

    // ====================
    // Field widths
    // ====================

    typedef logic [27:0] payload_t;
    typedef logic [3:0]  bank_sel_t;
    typedef logic [1:0]  bank_code_t;
    typedef logic [11:0] aram_addr_t;
    typedef logic [12:0] wram_addr_t;
    // Also used for the pooling length
    typedef logic [9:0]  oram_addr_t;
    typedef logic [7:0]  chan_t;
    typedef logic [9:0]  conv_len_t;
    // Encoded factor 1/2/4/8
    typedef logic [1:0]  fac_t;
    typedef logic [2:0]  wei_t;

    typedef struct packed {
        payload_t payload;
        opcode_e  opcode;
    } acmd_t;

    // One bit per executable command
    typedef struct packed {
        logic read;
        logic stat;
        logic pool;
        logic conv;
        logic wtoa;
        logic atow;
        logic otoa;
        logic itow;
        logic itoa;
    } exec_cmd_t;

    // Per-opcode load strobes, only set in the cycle of a valid word
    typedef struct packed {
        logic inf_oram;
        logic inf_wram;
        logic inf_aram;
        logic inf_conv;
        logic bias;
        logic mult;
        logic read;
        logic stat;
        logic pool;
        logic conv;
        logic wtoa;
        logic atow;
        logic otoa;
        logic itow;
        logic itoa;
    } cmd_load_t;

    typedef struct packed {
        bank_sel_t  aram_idx;
        bank_sel_t  wram_idx;
        bank_sel_t  oram_idx;
        bank_sel_t  omux_idx;
        aram_addr_t aram_add;
        wram_addr_t wram_add;
        oram_addr_t oram_add;
        aram_addr_t aram_len;
        wram_addr_t wram_len;
        oram_addr_t oram_len;
    } ram_cfg_t;

    typedef struct packed {
        chan_t      conv_ich;
        chan_t      conv_och;
        conv_len_t  conv_len;
        fac_t       strd_fac;
        fac_t       dila_fac;
        wei_t       conv_wei;
        oram_addr_t pool_len;
        fac_t       pool_fac;
        logic       relu_ena;
        logic       resn_ena;
        logic       maxp_ena;
        logic       avgp_ena;
    } layer_cfg_t;

    // ====================
    // Bit positions in the 32-bit word
    // ====================

    localparam int unsigned PAYLOAD_LSB   = 4;
    localparam int unsigned ARAM_IDX_LSB  = 16;
    localparam int unsigned WRAM_IDX_LSB  = 12;
    localparam int unsigned WRAM_CODE_LSB = 17;
    localparam int unsigned ORAM_IDX_LSB  = 8;
    localparam int unsigned OMUX_IDX_LSB  = 12;
    localparam int unsigned ARAM_ADD_LSB  = 20;
    localparam int unsigned ARAM_LEN_LSB  = 4;
    localparam int unsigned WRAM_ADD_LSB  = 19;
    localparam int unsigned WRAM_LEN_LSB  = 4;
    localparam int unsigned ORAM_ADD_LSB  = 22;
    localparam int unsigned ORAM_LEN_LSB  = 4;
    localparam int unsigned CONV_ICH_LSB  = 4;
    localparam int unsigned CONV_OCH_LSB  = 12;
    localparam int unsigned CONV_LEN_LSB  = 20;
    localparam int unsigned STRD_FAC_LSB  = 4;
    localparam int unsigned DILA_FAC_LSB  = 6;
    localparam int unsigned CONV_WEI_LSB  = 8;
    localparam int unsigned RESN_ENA_LSB  = 11;
    localparam int unsigned POOL_LEN_LSB  = 4;
    localparam int unsigned POOL_FAC_LSB  = 14;
    localparam int unsigned MAXP_ENA_LSB  = 16;
    localparam int unsigned AVGP_ENA_LSB  = 17;
    localparam int unsigned RELU_ENA_LSB  = 20;

endpackage

//--- src/cmd_decode.sv
// Command decoder producing per-opcode load strobes, the info pulse and the executed command
`timescale 1ns/1ns

module cmd_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   acmd_vld,
    input  eeg_cmd_pkg::acmd_t     acmd,
    output eeg_cmd_pkg::cmd_load_t load,
    output logic                   info_vld,
    output eeg_cmd_pkg::exec_cmd_t exec_cmd
);

    eeg_cmd_pkg::exec_cmd_t exec_d;

    // ====================
    // Opcode decode
    // ====================

    // Only place where the opcode is compared
    always_comb begin
        load = '0;
        if (acmd_vld) begin
            case (acmd.opcode)
                eeg_cmd_pkg::ITOA:     load.itoa     = 1'b1;
                eeg_cmd_pkg::ITOW:     load.itow     = 1'b1;
                eeg_cmd_pkg::OTOA:     load.otoa     = 1'b1;
                eeg_cmd_pkg::ATOW:     load.atow     = 1'b1;
                eeg_cmd_pkg::WTOA:     load.wtoa     = 1'b1;
                eeg_cmd_pkg::CONV:     load.conv     = 1'b1;
                eeg_cmd_pkg::POOL:     load.pool     = 1'b1;
                eeg_cmd_pkg::STAT:     load.stat     = 1'b1;
                eeg_cmd_pkg::READ:     load.read     = 1'b1;
                eeg_cmd_pkg::MULT:     load.mult     = 1'b1;
                eeg_cmd_pkg::BIAS:     load.bias     = 1'b1;
                eeg_cmd_pkg::INF_CONV: load.inf_conv = 1'b1;
                eeg_cmd_pkg::INF_ARAM: load.inf_aram = 1'b1;
                eeg_cmd_pkg::INF_WRAM: load.inf_wram = 1'b1;
                eeg_cmd_pkg::INF_ORAM: load.inf_oram = 1'b1;
                // Opcode 9 loads nothing
                default: load = '0;
            endcase
        end
    end

    // Executable subset, zero for INF_*, MULT, BIAS and opcode 9
    assign exec_d = '{
        read: load.read,
        stat: load.stat,
        pool: load.pool,
        conv: load.conv,
        wtoa: load.wtoa,
        atow: load.atow,
        otoa: load.otoa,
        itow: load.itow,
        itoa: load.itoa
    };

    // ====================
    // Registered outputs
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            info_vld <= 1'b0;
            exec_cmd <= '0;
        end else begin
            info_vld <= acmd_vld;
            // Every accepted word replaces the record
            if (acmd_vld) begin
                exec_cmd <= exec_d;
            end
        end
    end

endmodule

//--- src/ram_cfg_regs.sv
// RAM bank configuration registers for bank indices, start addresses and lengths
`timescale 1ns/1ns

module ram_cfg_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  eeg_cmd_pkg::cmd_load_t load,
    input  eeg_cmd_pkg::payload_t  payload,
    output eeg_cmd_pkg::ram_cfg_t  ram_cfg
);

    // Word bit positions are shifted down by the opcode width
    localparam int unsigned PL_OFS = eeg_cmd_pkg::PAYLOAD_LSB;

    eeg_cmd_pkg::bank_sel_t  aram_idx_f;
    eeg_cmd_pkg::bank_sel_t  wram_idx_f;
    eeg_cmd_pkg::bank_code_t wram_code_f;
    eeg_cmd_pkg::bank_sel_t  oram_idx_f;
    eeg_cmd_pkg::bank_sel_t  omux_idx_f;
    eeg_cmd_pkg::aram_addr_t aram_add_f;
    eeg_cmd_pkg::aram_addr_t aram_len_f;
    eeg_cmd_pkg::wram_addr_t wram_add_f;
    eeg_cmd_pkg::wram_addr_t wram_len_f;
    eeg_cmd_pkg::oram_addr_t oram_add_f;
    eeg_cmd_pkg::oram_addr_t oram_len_f;
    eeg_cmd_pkg::ram_cfg_t   cfg_d;

    // ====================
    // Payload fields
    // ====================

    assign aram_idx_f  = eeg_cmd_pkg::bank_sel_t'(payload >> (eeg_cmd_pkg::ARAM_IDX_LSB - PL_OFS));
    assign wram_idx_f  = eeg_cmd_pkg::bank_sel_t'(payload >> (eeg_cmd_pkg::WRAM_IDX_LSB - PL_OFS));
    assign oram_idx_f  = eeg_cmd_pkg::bank_sel_t'(payload >> (eeg_cmd_pkg::ORAM_IDX_LSB - PL_OFS));
    assign omux_idx_f  = eeg_cmd_pkg::bank_sel_t'(payload >> (eeg_cmd_pkg::OMUX_IDX_LSB - PL_OFS));
    assign aram_add_f  = eeg_cmd_pkg::aram_addr_t'(payload >> (eeg_cmd_pkg::ARAM_ADD_LSB - PL_OFS));
    assign aram_len_f  = eeg_cmd_pkg::aram_addr_t'(payload >> (eeg_cmd_pkg::ARAM_LEN_LSB - PL_OFS));
    assign wram_add_f  = eeg_cmd_pkg::wram_addr_t'(payload >> (eeg_cmd_pkg::WRAM_ADD_LSB - PL_OFS));
    assign wram_len_f  = eeg_cmd_pkg::wram_addr_t'(payload >> (eeg_cmd_pkg::WRAM_LEN_LSB - PL_OFS));
    assign oram_add_f  = eeg_cmd_pkg::oram_addr_t'(payload >> (eeg_cmd_pkg::ORAM_ADD_LSB - PL_OFS));
    assign oram_len_f  = eeg_cmd_pkg::oram_addr_t'(payload >> (eeg_cmd_pkg::ORAM_LEN_LSB - PL_OFS));

    // ITOW carries a 2-bit bank code instead of a bank mask
    assign wram_code_f =
        eeg_cmd_pkg::bank_code_t'(payload >> (eeg_cmd_pkg::WRAM_CODE_LSB - PL_OFS));

    // ====================
    // Next state
    // ====================

    always_comb begin
        cfg_d = ram_cfg;

        if (load.itoa || load.otoa || load.atow || load.wtoa || load.read) begin
            cfg_d.aram_idx = aram_idx_f;
        end

        // Code 0..3 selects one of four weight banks
        if (load.itow) begin
            cfg_d.wram_idx = eeg_cmd_pkg::bank_sel_t'(1) << wram_code_f;
        end else if (load.atow || load.wtoa || load.read) begin
            cfg_d.wram_idx = wram_idx_f;
        end

        if (load.otoa || load.stat || load.read) begin
            cfg_d.oram_idx = oram_idx_f;
        end

        // Output mux trails the ORAM index except on OTOA
        if (load.otoa) begin
            cfg_d.omux_idx = omux_idx_f;
        end else if (|load) begin
            cfg_d.omux_idx = ram_cfg.oram_idx;
        end

        if (load.itoa || load.inf_aram) begin
            cfg_d.aram_add = aram_add_f;
            cfg_d.aram_len = aram_len_f;
        end

        if (load.itow || load.inf_wram) begin
            cfg_d.wram_add = wram_add_f;
            cfg_d.wram_len = wram_len_f;
        end

        if (load.inf_oram) begin
            cfg_d.oram_add = oram_add_f;
            cfg_d.oram_len = oram_len_f;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_cfg <= '0;
        end else begin
            ram_cfg <= cfg_d;
        end
    end

endmodule

//--- src/layer_cfg_regs.sv
// Layer configuration registers for convolution, pooling and the layer enable flags
`timescale 1ns/1ns

module layer_cfg_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  eeg_cmd_pkg::cmd_load_t  load,
    input  eeg_cmd_pkg::payload_t   payload,
    output eeg_cmd_pkg::layer_cfg_t layer_cfg
);

    localparam int unsigned PL_OFS = eeg_cmd_pkg::PAYLOAD_LSB;

    eeg_cmd_pkg::chan_t      conv_ich_f;
    eeg_cmd_pkg::chan_t      conv_och_f;
    eeg_cmd_pkg::conv_len_t  conv_len_f;
    eeg_cmd_pkg::fac_t       strd_fac_f;
    eeg_cmd_pkg::fac_t       dila_fac_f;
    eeg_cmd_pkg::wei_t       conv_wei_f;
    eeg_cmd_pkg::oram_addr_t pool_len_f;
    eeg_cmd_pkg::fac_t       pool_fac_f;
    eeg_cmd_pkg::layer_cfg_t cfg_d;

    // ====================
    // Payload fields
    // ====================

    // INF_CONV layer shape
    assign conv_ich_f = eeg_cmd_pkg::chan_t'(payload >> (eeg_cmd_pkg::CONV_ICH_LSB - PL_OFS));
    assign conv_och_f = eeg_cmd_pkg::chan_t'(payload >> (eeg_cmd_pkg::CONV_OCH_LSB - PL_OFS));
    assign conv_len_f =
        eeg_cmd_pkg::conv_len_t'(payload >> (eeg_cmd_pkg::CONV_LEN_LSB - PL_OFS));

    // CONV kernel settings
    assign strd_fac_f = eeg_cmd_pkg::fac_t'(payload >> (eeg_cmd_pkg::STRD_FAC_LSB - PL_OFS));
    assign dila_fac_f = eeg_cmd_pkg::fac_t'(payload >> (eeg_cmd_pkg::DILA_FAC_LSB - PL_OFS));
    assign conv_wei_f = eeg_cmd_pkg::wei_t'(payload >> (eeg_cmd_pkg::CONV_WEI_LSB - PL_OFS));

    // POOL window
    assign pool_len_f =
        eeg_cmd_pkg::oram_addr_t'(payload >> (eeg_cmd_pkg::POOL_LEN_LSB - PL_OFS));
    assign pool_fac_f = eeg_cmd_pkg::fac_t'(payload >> (eeg_cmd_pkg::POOL_FAC_LSB - PL_OFS));

    // ====================
    // Next state
    // ====================

    always_comb begin
        cfg_d = layer_cfg;

        if (load.inf_conv) begin
            cfg_d.conv_ich = conv_ich_f;
            cfg_d.conv_och = conv_och_f;
            cfg_d.conv_len = conv_len_f;
        end

        // Bit 11 of CONV enables the residual path
        if (load.conv) begin
            cfg_d.strd_fac = strd_fac_f;
            cfg_d.dila_fac = dila_fac_f;
            cfg_d.conv_wei = conv_wei_f;
            cfg_d.resn_ena = payload[eeg_cmd_pkg::RESN_ENA_LSB - PL_OFS];
        end

        if (load.pool) begin
            cfg_d.pool_len = pool_len_f;
            cfg_d.pool_fac = pool_fac_f;
            cfg_d.maxp_ena = payload[eeg_cmd_pkg::MAXP_ENA_LSB - PL_OFS];
            cfg_d.avgp_ena = payload[eeg_cmd_pkg::AVGP_ENA_LSB - PL_OFS];
        end

        // Relu rides along with the OTOA transfer
        if (load.otoa) begin
            cfg_d.relu_ena = payload[eeg_cmd_pkg::RELU_ENA_LSB - PL_OFS];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_cfg <= '0;
        end else begin
            layer_cfg <= cfg_d;
        end
    end

endmodule

//--- src/eeg_cmd_top.sv
// Command decoder top level joining the opcode decoder and both configuration blocks
`timescale 1ns/1ns

module eeg_cmd_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    acmd_vld,
    input  eeg_cmd_pkg::acmd_t      acmd,
    output logic                    info_vld,
    output eeg_cmd_pkg::exec_cmd_t  exec_cmd,
    output eeg_cmd_pkg::ram_cfg_t   ram_cfg,
    output eeg_cmd_pkg::layer_cfg_t layer_cfg
);

    // Same-cycle load strobes shared by both register blocks
    eeg_cmd_pkg::cmd_load_t load;

    // ====================
    // Decoder
    // ====================

    cmd_decode u_cmd_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .acmd_vld (acmd_vld),
        .acmd     (acmd),
        .load     (load),
        .info_vld (info_vld),
        .exec_cmd (exec_cmd)
    );

    // ====================
    // Configuration
    // ====================

    // RAM banks, addresses and lengths
    ram_cfg_regs u_ram_cfg_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .payload (acmd.payload),
        .ram_cfg (ram_cfg)
    );

    // Convolution and pooling parameters
    layer_cfg_regs u_layer_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .payload   (acmd.payload),
        .layer_cfg (layer_cfg)
    );

endmodule

//--- testbench/eeg_cmd_assertions.sv
// Concurrent checks on the command decoder strobe timing and its one-hot command record
`timescale 1ns/1ns

module eeg_cmd_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   acmd_vld,
    input eeg_cmd_pkg::cmd_load_t load,
    input logic                   info_vld,
    input eeg_cmd_pkg::exec_cmd_t exec_cmd
);

    // ====================
    // Strobe timing
    // ====================

    // Info pulse is the valid strobe one clock later
    info_follows_vld: assert property (
        @(posedge clk) disable iff (!rst_n) info_vld == $past(acmd_vld)
    ) else $error("info_vld does not follow acmd_vld by one cycle");

    // No load strobe without a valid word
    load_idle_zero: assert property (
        @(posedge clk) disable iff (!rst_n) !acmd_vld |-> (load == '0)
    ) else $error("load strobes active while acmd_vld is low");

    // ====================
    // Command record
    // ====================

    exec_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(exec_cmd)
    ) else $error("exec_cmd has more than one bit set");

endmodule

//--- testbench/eeg_cmd_tb.sv
// Table-driven testbench for the EEG command decoder with a shadow reference model
`timescale 1ns/1ns

module eeg_cmd_tb;

    logic                    clk;
    logic                    rst_n;
    logic                    acmd_vld;
    eeg_cmd_pkg::acmd_t      acmd;
    logic                    info_vld;
    eeg_cmd_pkg::exec_cmd_t  exec_cmd;
    eeg_cmd_pkg::ram_cfg_t   ram_cfg;
    eeg_cmd_pkg::layer_cfg_t layer_cfg;

    // Stimulus and expected values per test
    string                   name_q[$];
    logic [31:0]             word_q[$];
    int                      gap_q[$];
    logic                    info_q[$];
    eeg_cmd_pkg::exec_cmd_t  exec_q[$];
    eeg_cmd_pkg::ram_cfg_t   ram_q[$];
    eeg_cmd_pkg::layer_cfg_t layer_q[$];

    // Shadow configuration
    eeg_cmd_pkg::ram_cfg_t   ram_m;
    eeg_cmd_pkg::layer_cfg_t layer_m;

    int          pass_count;
    int          fail_count;
    int          cycle_count;
    int          cycle_limit;

    eeg_cmd_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .acmd_vld  (acmd_vld),
        .acmd      (acmd),
        .info_vld  (info_vld),
        .exec_cmd  (exec_cmd),
        .ram_cfg   (ram_cfg),
        .layer_cfg (layer_cfg)
    );

    bind cmd_decode eeg_cmd_assertions u_cmd_assertions (
        .clk      (clk),
        .rst_n    (rst_n),
        .acmd_vld (acmd_vld),
        .load     (load),
        .info_vld (info_vld),
        .exec_cmd (exec_cmd)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // ====================
    // Reference model
    // ====================

    task automatic model_step(input logic [31:0] w, output eeg_cmd_pkg::exec_cmd_t e);
        eeg_cmd_pkg::bank_sel_t old_oram;
        old_oram = ram_m.oram_idx;
        e = '0;
        case (w[3:0])
            4'd0: begin
                e.itoa = 1'b1;
                ram_m.aram_idx = w[19:16];
                ram_m.aram_len = w[15:4];
                ram_m.aram_add = w[31:20];
            end
            4'd1: begin
                e.itow = 1'b1;
                case (w[18:17])
                    2'd0:    ram_m.wram_idx = 4'b0001;
                    2'd1:    ram_m.wram_idx = 4'b0010;
                    2'd2:    ram_m.wram_idx = 4'b0100;
                    default: ram_m.wram_idx = 4'b1000;
                endcase
                ram_m.wram_len = w[16:4];
                ram_m.wram_add = w[31:19];
            end
            4'd2: begin
                e.otoa = 1'b1;
                ram_m.aram_idx = w[19:16];
                ram_m.omux_idx = w[15:12];
                ram_m.oram_idx = w[11:8];
                layer_m.relu_ena = w[20];
            end
            4'd3, 4'd4: begin
                e.atow = (w[3:0] == 4'd3);
                e.wtoa = (w[3:0] == 4'd4);
                ram_m.aram_idx = w[19:16];
                ram_m.wram_idx = w[15:12];
            end
            4'd5: begin
                e.conv = 1'b1;
                layer_m.strd_fac = w[5:4];
                layer_m.dila_fac = w[7:6];
                layer_m.conv_wei = w[10:8];
                layer_m.resn_ena = w[11];
            end
            4'd6: begin
                e.pool = 1'b1;
                layer_m.pool_len = w[13:4];
                layer_m.pool_fac = w[15:14];
                layer_m.maxp_ena = w[16];
                layer_m.avgp_ena = w[17];
            end
            4'd7: begin
                e.stat = 1'b1;
                ram_m.oram_idx = w[11:8];
            end
            4'd8: begin
                e.read = 1'b1;
                ram_m.aram_idx = w[19:16];
                ram_m.wram_idx = w[15:12];
                ram_m.oram_idx = w[11:8];
            end
            4'd12: begin
                layer_m.conv_ich = w[11:4];
                layer_m.conv_och = w[19:12];
                layer_m.conv_len = w[29:20];
            end
            4'd13: begin
                ram_m.aram_len = w[15:4];
                ram_m.aram_add = w[31:20];
            end
            4'd14: begin
                ram_m.wram_len = w[16:4];
                ram_m.wram_add = w[31:19];
            end
            4'd15: begin
                ram_m.oram_add = w[31:22];
                ram_m.oram_len = w[13:4];
            end
            // MULT, BIAS and opcode 9 touch no field
            default: e = '0;
        endcase
        // Opcode 9 raises no load, so the output mux holds
        if (w[3:0] != 4'd2 && w[3:0] != 4'd9) begin
            ram_m.omux_idx = old_oram;
        end
    endtask

    // ====================
    // Table construction
    // ====================

    function automatic logic [31:0] rand_word(input logic [3:0] op);
        logic [31:0] r;
        r = $urandom();
        return {r[31:4], op};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] w, input int gap);
        eeg_cmd_pkg::exec_cmd_t e;
        model_step(w, e);
        name_q.push_back(name);
        word_q.push_back(w);
        gap_q.push_back(gap);
        info_q.push_back(1'b1);
        exec_q.push_back(e);
        ram_q.push_back(ram_m);
        layer_q.push_back(layer_m);
    endtask

    task automatic build_table();
        logic [31:0] w;
        int unsigned k;
        add_entry("itoa_rand", rand_word(4'd0), 1);
        for (k = 0; k < 4; k++) begin
            w = rand_word(4'd1);
            w[18:17] = k[1:0];
            add_entry($sformatf("itow_code%0d", k), w, 1);
        end
        add_entry("inf_aram", rand_word(4'd13), 0);
        add_entry("inf_wram", rand_word(4'd14), 0);
        add_entry("inf_oram", rand_word(4'd15), 1);
        // OTOA sets the mux and the next word copies the ORAM index
        add_entry("otoa_mux", rand_word(4'd2), 0);
        add_entry("stat_mux", rand_word(4'd7), 0);
        add_entry("atow", rand_word(4'd3), 0);
        add_entry("wtoa", rand_word(4'd4), 0);
        add_entry("read", rand_word(4'd8), 1);
        add_entry("inf_conv", rand_word(4'd12), 1);
        w = rand_word(4'd5);
        w[11] = 1'b1;
        add_entry("conv_resn_on", w, 1);
        w[11] = 1'b0;
        add_entry("conv_resn_off", w, 1);
        w = rand_word(4'd6);
        w[17:16] = 2'b01;
        add_entry("pool_max", w, 1);
        w[17:16] = 2'b10;
        add_entry("pool_avg", w, 1);
        w = rand_word(4'd2);
        w[20] = 1'b1;
        add_entry("otoa_relu_on", w, 1);
        w[20] = 1'b0;
        add_entry("otoa_relu_off", w, 1);
        add_entry("mult_rand", rand_word(4'd10), 1);
        add_entry("bias_rand", rand_word(4'd11), 1);
        add_entry("opcode9", rand_word(4'd9), 1);
        for (k = 0; k < 6; k++) begin
            add_entry($sformatf("burst%0d", k), rand_word(4'($urandom_range(8, 0))), 0);
        end
        for (k = 0; k < 20; k++) begin
            w = rand_word(4'($urandom_range(15, 0)));
            add_entry($sformatf("mix%0d", k), w, int'($urandom_range(1, 0)));
        end
    endtask

    // ====================
    // Checks
    // ====================

    task automatic check_entry(input int i);
        int errs;
        errs = 0;
        if (info_vld !== info_q[i]) begin
            $display("FAILED %s info_vld expected %b actual %b", name_q[i], info_q[i], info_vld);
            errs++;
        end
        if (exec_cmd !== exec_q[i]) begin
            $display("FAILED %s exec_cmd expected %h actual %h", name_q[i], exec_q[i], exec_cmd);
            errs++;
        end
        if (ram_cfg !== ram_q[i]) begin
            $display("FAILED %s ram_cfg expected %h actual %h", name_q[i], ram_q[i], ram_cfg);
            errs++;
        end
        if (layer_cfg !== layer_q[i]) begin
            $display("FAILED %s layer_cfg expected %h actual %h",
                     name_q[i], layer_q[i], layer_cfg);
            errs++;
        end
        if (errs == 0) begin
            pass_count++;
            $display("PASS   %s", name_q[i]);
        end else begin
            fail_count++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        acmd_vld    = 1'b0;
        acmd        = '0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        ram_m       = '0;
        layer_m     = '0;
        void'($urandom(21297));
        build_table();
        cycle_limit = 4 * name_q.size() + 50;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (info_vld !== 1'b0 || exec_cmd !== '0 || ram_cfg !== '0 || layer_cfg !== '0) begin
            $display("FAILED reset expected all zero actual info=%b exec=%h ram=%h layer=%h",
                     info_vld, exec_cmd, ram_cfg, layer_cfg);
            fail_count++;
        end else begin
            pass_count++;
            $display("PASS   reset");
        end

        for (int i = 0; i < name_q.size(); i++) begin
            acmd_vld = 1'b1;
            acmd     = eeg_cmd_pkg::acmd_t'(word_q[i]);
            @(negedge clk);
            acmd_vld = 1'b0;
            check_entry(i);
            repeat (gap_q[i]) @(negedge clk);
        end

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- eeg_cmd_top.f
src/eeg_cmd_pkg.sv
src/cmd_decode.sv
src/ram_cfg_regs.sv
src/layer_cfg_regs.sv
src/eeg_cmd_top.sv
testbench/eeg_cmd_assertions.sv
testbench/eeg_cmd_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the command decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module eeg_cmd_tb -f eeg_cmd_top.f

out=$(./obj_dir/Veeg_cmd_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
